// File: calib/calib_controller.sv
`timescale 1ns/10ps
`default_nettype none

module calib_controller #(
	parameter int LANES       = 12,
	parameter int MATCH_COUNT = 4,
	parameter int SLIP_SETTLE = 2
) (
	input  wire                           sys_clk_i,
	input  wire                           rst_i,
	// synchronized control pin, restarts calibration
	input  wire                           hold_i,
	input  wire adc_phy_pkg::sel_word_t   sel_i,
	output adc_phy_pkg::calib_cmd_t       cmd_o,
	output logic                          calib_complete_o,
	output logic                          calib_error_o
);

	localparam int LINE_W   = adc_phy_pkg::LINE_W;
	localparam int MATCH_W  = $clog2(MATCH_COUNT + 1);
	localparam int SETTLE_W = $clog2(SLIP_SETTLE + 1);
	localparam int SLIP_W   = $clog2(adc_phy_pkg::ISERDES_BITS + 1);

	typedef enum logic [1:0] {
		ST_CHECK,
		ST_SETTLE,
		ST_STOP
	} state_t;

	state_t                  state;
	logic [LINE_W-1:0]       line_idx;
	// 0 while on I lines, 1 on Q lines
	logic                    on_q;
	logic [MATCH_W-1:0]      match_cnt;
	logic [SETTLE_W-1:0]     settle_cnt;
	logic [SLIP_W-1:0]       slip_cnt;
	logic                    slip_i_q;
	logic                    slip_q_q;
	adc_phy_pkg::lane_word_t cur_word;
	logic                    word_ok;
	logic                    last_line;

	assign cur_word  = on_q ? sel_i.word_q : sel_i.word_i;
	assign word_ok   = (cur_word == adc_phy_pkg::TRAIN_PATTERN);
	assign last_line = (line_idx == LINE_W'(LANES - 1));

	assign cmd_o = '{line: line_idx, slip_i: slip_i_q, slip_q: slip_q_q};

	//////////////////////////////
	// calibration fsm
	//////////////////////////////
	always_ff @(posedge sys_clk_i) begin
		if (rst_i || hold_i) begin
			state            <= ST_CHECK;
			line_idx         <= '0;
			on_q             <= 1'b0;
			match_cnt        <= '0;
			settle_cnt       <= '0;
			slip_cnt         <= '0;
			slip_i_q         <= 1'b0;
			slip_q_q         <= 1'b0;
			calib_complete_o <= 1'b0;
			calib_error_o    <= 1'b0;
		end else begin
			// slips are single cycle pulses
			slip_i_q <= 1'b0;
			slip_q_q <= 1'b0;
			case (state)
				ST_CHECK: begin
					if (sel_i.valid && word_ok) begin
						if (match_cnt == MATCH_W'(MATCH_COUNT - 1)) begin
							// line locked, move on
							match_cnt <= '0;
							slip_cnt  <= '0;
							if (last_line) begin
								line_idx <= '0;
								if (on_q) begin
									state            <= ST_STOP;
									calib_complete_o <= 1'b1;
								end else begin
									on_q <= 1'b1;
								end
							end else begin
								line_idx <= line_idx + 1'b1;
							end
						end else begin
							match_cnt <= match_cnt + 1'b1;
						end
					end else if (sel_i.valid) begin
						if (slip_cnt == SLIP_W'(adc_phy_pkg::ISERDES_BITS)) begin
							// every rotation tried, line is dead
							state         <= ST_STOP;
							calib_error_o <= 1'b1;
						end else begin
							match_cnt <= '0;
							slip_cnt  <= slip_cnt + 1'b1;
							slip_i_q  <= ~on_q;
							slip_q_q  <= on_q;
							state     <= ST_SETTLE;
						end
					end
				end
				ST_SETTLE: begin
					// skip words that straddle the slip
					if (sel_i.valid) begin
						if (settle_cnt == SETTLE_W'(SLIP_SETTLE - 1)) begin
							settle_cnt <= '0;
							state      <= ST_CHECK;
						end else begin
							settle_cnt <= settle_cnt + 1'b1;
						end
					end
				end
				default: begin
					// stopped until reset or hold
				end
			endcase
		end
	end

	a_done_xor_err: assert property (@(posedge sys_clk_i) disable iff (rst_i)
		!(calib_complete_o && calib_error_o));

endmodule

`default_nettype wire

// File: calib/line_select.sv
`timescale 1ns/10ps
`default_nettype none

module line_select #(
	parameter int LANES = 12
) (
	input  wire                                       sys_clk_i,
	input  wire                                       rst_i,
	input  wire adc_phy_pkg::calib_cmd_t              cmd_i,
	input  wire adc_phy_pkg::lane_word_t [LANES-1:0]  words_i_i,
	input  wire adc_phy_pkg::lane_word_t [LANES-1:0]  words_q_i,
	input  wire                                       word_stb_i,
	output adc_phy_pkg::sel_word_t                    sel_o,
	output logic [LANES-1:0]                          slip_mask_i_o,
	output logic [LANES-1:0]                          slip_mask_q_o,
	output adc_phy_pkg::lane_word_t [LANES-1:0]       words_i_o,
	output adc_phy_pkg::lane_word_t [LANES-1:0]       words_q_o,
	output logic                                      valid_o
);

	adc_phy_pkg::lane_word_t sel_i_q;
	adc_phy_pkg::lane_word_t sel_q_q;

	// one hot slip at the selected line
	assign slip_mask_i_o = cmd_i.slip_i ? (LANES'(1) << cmd_i.line) : '0;
	assign slip_mask_q_o = cmd_i.slip_q ? (LANES'(1) << cmd_i.line) : '0;

	// payload follows the strobe
	always_ff @(posedge sys_clk_i) begin
		if (word_stb_i) begin
			sel_i_q   <= words_i_i[cmd_i.line];
			sel_q_q   <= words_q_i[cmd_i.line];
			words_i_o <= words_i_i;
			words_q_o <= words_q_i;
		end
	end

	always_ff @(posedge sys_clk_i) begin
		if (rst_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= word_stb_i;
		end
	end

	assign sel_o = '{word_i: sel_i_q, word_q: sel_q_q, valid: valid_o};

	a_slip_in_range: assert property (@(posedge sys_clk_i) disable iff (rst_i)
		(cmd_i.slip_i || cmd_i.slip_q) |-> (int'(cmd_i.line) < LANES));

endmodule

`default_nettype wire

// File: common/adc_phy_pkg.sv
`default_nettype none

////////////////////////////////
// adc front end shared types
////////////////////////////////

package adc_phy_pkg;

	// bits per deserialized lane word
	localparam int ISERDES_BITS = 8;

	// line index width, up to 16 lanes per channel
	localparam int LINE_W = 4;

	// one deserialized word of a lane
	typedef logic [ISERDES_BITS-1:0] lane_word_t;

	// training word, all 8 rotations distinct
	localparam lane_word_t TRAIN_PATTERN = 8'h2C;

	// line pointer plus per channel slip pulses
	typedef struct packed {
		logic [LINE_W-1:0] line;
		logic              slip_i;
		logic              slip_q;
	} calib_cmd_t;

	// selected word pair from the line mux
	typedef struct packed {
		lane_word_t word_i;
		lane_word_t word_q;
		logic       valid;
	} sel_word_t;

endpackage

`default_nettype wire

// File: deser/lane_deserializer.sv
`timescale 1ns/10ps
`default_nettype none

module lane_deserializer #(
	parameter int LANES = 12
) (
	input  wire                                 sys_clk_i,
	input  wire                                 rst_i,
	input  wire  [LANES-1:0]                    serial_i,
	input  wire  [LANES-1:0]                    slip_mask_i,
	output adc_phy_pkg::lane_word_t [LANES-1:0] words_o,
	output logic                                word_stb_o
);

	localparam int BITS = adc_phy_pkg::ISERDES_BITS;
	localparam int CNT_W = $clog2(BITS);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BITS - 1);

	adc_phy_pkg::lane_word_t [LANES-1:0] shift_q;
	logic [LANES-1:0][CNT_W-1:0]         bit_cnt;
	// last bit of a word arrives this cycle
	logic [LANES-1:0]                    wrap;

	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			// held lane takes no bit, so no wrap
			wrap[l] = (bit_cnt[l] == CNT_LAST) && !slip_mask_i[l];
		end
	end

	//////////////////////////////
	// per lane bit counters
	//////////////////////////////
	always_ff @(posedge sys_clk_i) begin
		if (rst_i) begin
			bit_cnt <= '0;
		end else begin
			for (int l = 0; l < LANES; l++) begin
				if (wrap[l]) begin
					bit_cnt[l] <= '0;
				end else if (!slip_mask_i[l]) begin
					bit_cnt[l] <= bit_cnt[l] + 1'b1;
				end
			end
		end
	end

	//////////////////////////////
	// shift and word latch
	//////////////////////////////
	always_ff @(posedge sys_clk_i) begin
		for (int l = 0; l < LANES; l++) begin
			// slip drops one bit, boundary moves one bit later
			if (!slip_mask_i[l]) begin
				shift_q[l] <= {shift_q[l][BITS-2:0], serial_i[l]};
			end
			// msb first, newest bit lands at lsb
			if (wrap[l]) begin
				words_o[l] <= {shift_q[l][BITS-2:0], serial_i[l]};
			end
		end
	end

	// strobe tracks lane 0 word boundary
	always_ff @(posedge sys_clk_i) begin
		if (rst_i) begin
			word_stb_o <= 1'b0;
		end else begin
			word_stb_o <= wrap[0];
		end
	end

	// only one line is slipped at a time
	a_slip_onehot: assert property (@(posedge sys_clk_i) disable iff (rst_i)
		$onehot0(slip_mask_i));

	// words are at least BITS cycles apart
	a_stb_spacing: assert property (@(posedge sys_clk_i) disable iff (rst_i)
		word_stb_o |=> !word_stb_o);

endmodule

`default_nettype wire

// File: hdl/adc_io_phy.sv
`timescale 1ns/10ps
`default_nettype none

module adc_io_phy #(
	parameter int LANES       = 12,
	parameter int MATCH_COUNT = 4,
	parameter int SLIP_SETTLE = 2
) (
	input  wire                                       sys_clk_i,
	input  wire                                       rst_i,
	// serial lanes, one bit per clock, msb first
	input  wire  [LANES-1:0]                          data_i_i,
	input  wire  [LANES-1:0]                          data_q_i,
	// debug control
	input  wire                                       dbg_control_pin_i,
	input  wire                                       dbg_bitslip_i_i,
	input  wire                                       dbg_bitslip_q_i,
	input  wire  [adc_phy_pkg::LINE_W-1:0]            dbg_mux_lines_i,
	// parallel words out
	output adc_phy_pkg::lane_word_t [LANES-1:0]       data_o_i,
	output adc_phy_pkg::lane_word_t [LANES-1:0]       data_o_q,
	output logic                                      data_valid_o,
	output logic                                      adc_calib_complete_o,
	output logic                                      calib_error_o
);

	//////////////////////////////
	// wires
	//////////////////////////////
	adc_phy_pkg::lane_word_t [LANES-1:0] words_i;
	adc_phy_pkg::lane_word_t [LANES-1:0] words_q;
	// lane 0 of I sets the word timing
	logic                                i_word_stb;
	logic [LANES-1:0]                    slip_i_mask;
	logic [LANES-1:0]                    slip_q_mask;
	adc_phy_pkg::sel_word_t              sel_word;
	adc_phy_pkg::calib_cmd_t             auto_cmd;
	adc_phy_pkg::calib_cmd_t             calib_cmd;
	logic                                calib_hold;

	//////////////////////////////
	// deserializers
	//////////////////////////////
	lane_deserializer #(
		.LANES       (LANES)
	) i_deser_i (
		.sys_clk_i   (sys_clk_i),
		.rst_i       (rst_i),
		.serial_i    (data_i_i),
		.slip_mask_i (slip_i_mask),
		.words_o     (words_i),
		.word_stb_o  (i_word_stb)
	);

	// q strobe not needed, both channels share boundaries until slipped
	lane_deserializer #(
		.LANES       (LANES)
	) i_deser_q (
		.sys_clk_i   (sys_clk_i),
		.rst_i       (rst_i),
		.serial_i    (data_q_i),
		.slip_mask_i (slip_q_mask),
		.words_o     (words_q),
		.word_stb_o  ()
	);

	//////////////////////////////
	// line mux and slip routing
	//////////////////////////////
	line_select #(
		.LANES         (LANES)
	) i_line_select (
		.sys_clk_i     (sys_clk_i),
		.rst_i         (rst_i),
		.cmd_i         (calib_cmd),
		.words_i_i     (words_i),
		.words_q_i     (words_q),
		.word_stb_i    (i_word_stb),
		.sel_o         (sel_word),
		.slip_mask_i_o (slip_i_mask),
		.slip_mask_q_o (slip_q_mask),
		.words_i_o     (data_o_i),
		.words_q_o     (data_o_q),
		.valid_o       (data_valid_o)
	);

	//////////////////////////////
	// auto calibration
	//////////////////////////////
	calib_controller #(
		.LANES            (LANES),
		.MATCH_COUNT      (MATCH_COUNT),
		.SLIP_SETTLE      (SLIP_SETTLE)
	) i_calib_controller (
		.sys_clk_i        (sys_clk_i),
		.rst_i            (rst_i),
		.hold_i           (calib_hold),
		.sel_i            (sel_word),
		.cmd_o            (auto_cmd),
		.calib_complete_o (adc_calib_complete_o),
		.calib_error_o    (calib_error_o)
	);

	//////////////////////////////
	// manual or auto command
	//////////////////////////////
	mode_switch i_mode_switch (
		.sys_clk_i     (sys_clk_i),
		.rst_i         (rst_i),
		.control_pin_i (dbg_control_pin_i),
		.bitslip_i_i   (dbg_bitslip_i_i),
		.bitslip_q_i   (dbg_bitslip_q_i),
		.mux_lines_i   (dbg_mux_lines_i),
		.auto_cmd_i    (auto_cmd),
		.cmd_o         (calib_cmd),
		.hold_o        (calib_hold)
	);

endmodule

`default_nettype wire

// File: hdl/mode_switch.sv
`timescale 1ns/10ps
`default_nettype none

module mode_switch (
	input  wire                              sys_clk_i,
	input  wire                              rst_i,
	input  wire                              control_pin_i,
	input  wire                              bitslip_i_i,
	input  wire                              bitslip_q_i,
	input  wire [adc_phy_pkg::LINE_W-1:0]    mux_lines_i,
	input  wire adc_phy_pkg::calib_cmd_t     auto_cmd_i,
	output adc_phy_pkg::calib_cmd_t          cmd_o,
	output logic                             hold_o
);

	logic                    pin_meta;
	logic                    pin_sync;
	logic                    bitslip_i_d;
	logic                    bitslip_q_d;
	logic                    slip_i_pulse;
	logic                    slip_q_pulse;
	adc_phy_pkg::calib_cmd_t man_cmd;

	//////////////////////////////
	// control pin sync
	//////////////////////////////
	always_ff @(posedge sys_clk_i) begin
		if (rst_i) begin
			pin_meta <= 1'b0;
			pin_sync <= 1'b0;
		end else begin
			pin_meta <= control_pin_i;
			pin_sync <= pin_meta;
		end
	end

	// manual bitslip rising edges, one cycle pulses
	always_ff @(posedge sys_clk_i) begin
		if (rst_i) begin
			bitslip_i_d  <= 1'b0;
			bitslip_q_d  <= 1'b0;
			slip_i_pulse <= 1'b0;
			slip_q_pulse <= 1'b0;
		end else begin
			bitslip_i_d  <= bitslip_i_i;
			bitslip_q_d  <= bitslip_q_i;
			slip_i_pulse <= bitslip_i_i & ~bitslip_i_d;
			slip_q_pulse <= bitslip_q_i & ~bitslip_q_d;
		end
	end

	assign man_cmd = '{line: mux_lines_i, slip_i: slip_i_pulse, slip_q: slip_q_pulse};

	// pin high means debug owns the line mux
	assign cmd_o  = pin_sync ? man_cmd : auto_cmd_i;
	assign hold_o = pin_sync;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module tb_adc_io_phy \
	-f sources.f -o sim_tb > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "^Simulation PASSED$" sim.log && echo "run passed" \
	|| { echo "run failed"; exit 1; }

// File: sources.f
common/adc_phy_pkg.sv
deser/lane_deserializer.sv
calib/line_select.sv
calib/calib_controller.sv
hdl/mode_switch.sv
hdl/adc_io_phy.sv
tb/adc_lane_model.sv
tb/tb_adc_io_phy.sv

// File: tb/adc_lane_model.sv
`timescale 1ns/10ps
`default_nettype none

module adc_lane_model #(
	parameter int          LANES = 12,
	parameter logic [31:0] SEED  = 32'h1b49_784b
) (
	input  wire              clk_i,
	// 0 sends the training word, 1 sends a per lane counter
	input  wire              data_mode_i,
	// I lanes forced low, for the dead line case
	input  wire  [LANES-1:0] zero_i_i,
	output logic [LANES-1:0] data_i_o,
	output logic [LANES-1:0] data_q_o
);

	localparam adc_phy_pkg::lane_word_t TRAIN = adc_phy_pkg::TRAIN_PATTERN;

	adc_phy_pkg::lane_word_t word_i [LANES];
	adc_phy_pkg::lane_word_t word_q [LANES];
	logic [2:0]              idx_i  [LANES];
	logic [2:0]              idx_q  [LANES];
	logic [31:0]             rnd;

	// plain 32 bit lcg
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// random start bit per lane, upper lcg bits
	initial begin
		rnd = SEED;
		for (int l = 0; l < LANES; l++) begin
			rnd       = lcg_next(rnd);
			idx_i[l]  = rnd[18:16];
			rnd       = lcg_next(rnd);
			idx_q[l]  = rnd[18:16];
			word_i[l] = TRAIN;
			word_q[l] = TRAIN;
		end
	end

	//////////////////////////////
	// serializer, msb first
	//////////////////////////////
	always @(posedge clk_i) begin
		for (int l = 0; l < LANES; l++) begin
			// new word only at the lane's own boundary
			if (idx_i[l] == 3'd7) begin
				idx_i[l]  <= 3'd0;
				word_i[l] <= data_mode_i ? word_i[l] + 8'd1 : TRAIN;
			end else begin
				idx_i[l] <= idx_i[l] + 3'd1;
			end
			if (idx_q[l] == 3'd7) begin
				idx_q[l]  <= 3'd0;
				word_q[l] <= data_mode_i ? word_q[l] + 8'd1 : TRAIN;
			end else begin
				idx_q[l] <= idx_q[l] + 3'd1;
			end
		end
	end

	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			data_i_o[l] = zero_i_i[l] ? 1'b0 : word_i[l][3'd7 - idx_i[l]];
			data_q_o[l] = word_q[l][3'd7 - idx_q[l]];
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_adc_io_phy.sv
`timescale 1ns/10ps
`default_nettype none

module tb_adc_io_phy;

	localparam int LANES       = 12;
	localparam int MATCH_COUNT = 4;
	localparam int SLIP_SETTLE = 2;
	localparam int BITS        = adc_phy_pkg::ISERDES_BITS;
	localparam int MAN_LINE    = 5;
	localparam adc_phy_pkg::lane_word_t TRAIN = adc_phy_pkg::TRAIN_PATTERN;
	// training word seen one bit later
	localparam adc_phy_pkg::lane_word_t TRAIN_ROT = {TRAIN[6:0], TRAIN[7]};
	// worst case words per calibration times cycles per word and period
	localparam longint WD_NS = longint'(2 * LANES * BITS *
		(MATCH_COUNT + BITS * (SLIP_SETTLE + 1))) * BITS * 40;

	typedef adc_phy_pkg::lane_word_t [LANES-1:0] word_arr_t;

	logic                        sys_clk_i;
	logic                        rst_i;
	logic [LANES-1:0]            data_i_i;
	logic [LANES-1:0]            data_q_i;
	logic                        dbg_control_pin_i;
	logic                        dbg_bitslip_i_i;
	logic                        dbg_bitslip_q_i;
	logic [adc_phy_pkg::LINE_W-1:0] dbg_mux_lines_i;
	word_arr_t                   data_o_i;
	word_arr_t                   data_o_q;
	logic                        data_valid_o;
	logic                        adc_calib_complete_o;
	logic                        calib_error_o;

	logic                        data_mode;
	logic [LANES-1:0]            zero_lanes;
	word_arr_t                   prev_i;
	word_arr_t                   prev_q;
	int                          fail_cnt;
	int                          tests_run;

	// check windows
	logic chk_early, chk_noerr, chk_train, chk_incr, chk_manual, chk_hold, chk_errcase;

	adc_io_phy #(
		.LANES (LANES), .MATCH_COUNT (MATCH_COUNT), .SLIP_SETTLE (SLIP_SETTLE)
	) i_adc_io_phy (
		.sys_clk_i (sys_clk_i), .rst_i (rst_i),
		.data_i_i (data_i_i), .data_q_i (data_q_i),
		.dbg_control_pin_i (dbg_control_pin_i),
		.dbg_bitslip_i_i (dbg_bitslip_i_i), .dbg_bitslip_q_i (dbg_bitslip_q_i),
		.dbg_mux_lines_i (dbg_mux_lines_i),
		.data_o_i (data_o_i), .data_o_q (data_o_q), .data_valid_o (data_valid_o),
		.adc_calib_complete_o (adc_calib_complete_o), .calib_error_o (calib_error_o)
	);

	adc_lane_model #(.LANES (LANES)) i_lane_model (
		.clk_i (sys_clk_i), .data_mode_i (data_mode), .zero_i_i (zero_lanes),
		.data_i_o (data_i_i), .data_q_o (data_q_i)
	);

	initial sys_clk_i = 1'b0;
	always #20 sys_clk_i = ~sys_clk_i;

	// every lane at the training word except lane hot
	function automatic logic lanes_ok(input word_arr_t w, input int hot,
		input adc_phy_pkg::lane_word_t hot_word);
		logic ok;
		ok = 1'b1;
		for (int l = 0; l < LANES; l++) begin
			if (w[l] != ((l == hot) ? hot_word : TRAIN)) ok = 1'b0;
		end
		return ok;
	endfunction

	function automatic logic counts_up(input word_arr_t w, input word_arr_t p);
		logic ok;
		ok = 1'b1;
		for (int l = 0; l < LANES; l++) begin
			if (w[l] != p[l] + 8'd1) ok = 1'b0;
		end
		return ok;
	endfunction

	task automatic log_failure(input string msg);
		fail_cnt++;
		$display("Fail %0t: %s", $time, msg);
	endtask

	always @(posedge sys_clk_i) begin
		if (data_valid_o) begin
			prev_i <= data_o_i;
			prev_q <= data_o_q;
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////
	a_early_quiet: assert property (@(posedge sys_clk_i)
		chk_early |-> !data_valid_o && !adc_calib_complete_o && !calib_error_o)
		else log_failure("outputs active during reset");
	a_no_error: assert property (@(posedge sys_clk_i) chk_noerr |-> !calib_error_o)
		else log_failure("unexpected calib error");
	a_train: assert property (@(posedge sys_clk_i) chk_train && data_valid_o |->
		lanes_ok(data_o_i, -1, TRAIN) && lanes_ok(data_o_q, -1, TRAIN))
		else log_failure("lane not at training word");
	a_incr: assert property (@(posedge sys_clk_i) chk_incr && data_valid_o |->
		counts_up(data_o_i, prev_i) && counts_up(data_o_q, prev_q))
		else log_failure("counter data not incrementing");
	a_manual: assert property (@(posedge sys_clk_i) chk_manual && data_valid_o |->
		lanes_ok(data_o_i, MAN_LINE, TRAIN_ROT) && lanes_ok(data_o_q, -1, TRAIN))
		else log_failure("manual slip result wrong");
	a_hold_low: assert property (@(posedge sys_clk_i)
		chk_hold || chk_errcase |-> !adc_calib_complete_o)
		else log_failure("calib complete while held");

	task automatic wait_valid(input int n);
		repeat (n) begin
			@(negedge sys_clk_i);
			while (!data_valid_o) @(negedge sys_clk_i);
		end
	endtask

	task automatic report(input string name, input int fails_before);
		tests_run++;
		if (fail_cnt == fails_before) $display("test %s: ok", name);
		else $display("test %s: %0d failed checks", name, fail_cnt - fails_before);
	endtask

	// ends a run that never finishes
	initial begin
		#(WD_NS);
		$display("watchdog expired after %0d ns, test did not finish", WD_NS);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		int f;
		rst_i = 1'b1;
		dbg_control_pin_i = 1'b0;
		dbg_bitslip_i_i = 1'b0;
		dbg_bitslip_q_i = 1'b0;
		dbg_mux_lines_i = '0;
		data_mode = 1'b0;
		zero_lanes = '0;
		{chk_early, chk_noerr, chk_train, chk_incr, chk_manual, chk_hold, chk_errcase} = '0;
		fail_cnt = 0;
		tests_run = 0;

		// reset and quiet outputs
		f = fail_cnt;
		@(posedge sys_clk_i);
		chk_early <= 1'b1;
		repeat (4) @(posedge sys_clk_i);
		rst_i <= 1'b0;
		repeat (6) @(posedge sys_clk_i);
		chk_early <= 1'b0;
		chk_noerr <= 1'b1;
		wait_valid(1);
		report("reset", f);

		// auto calibration
		f = fail_cnt;
		@(negedge sys_clk_i);
		while (!adc_calib_complete_o) @(negedge sys_clk_i);
		@(posedge sys_clk_i);
		chk_train <= 1'b1;
		wait_valid(8);
		report("auto_calib", f);

		// counter data
		f = fail_cnt;
		@(posedge sys_clk_i);
		chk_train <= 1'b0;
		data_mode <= 1'b1;
		wait_valid(2);
		@(posedge sys_clk_i);
		chk_incr <= 1'b1;
		wait_valid(16);
		@(posedge sys_clk_i);
		chk_incr <= 1'b0;
		data_mode <= 1'b0;
		wait_valid(3);
		report("data_mode", f);

		// manual slip on one I line
		f = fail_cnt;
		@(posedge sys_clk_i);
		dbg_mux_lines_i <= adc_phy_pkg::LINE_W'(MAN_LINE);
		dbg_control_pin_i <= 1'b1;
		repeat (4) @(posedge sys_clk_i);
		chk_hold <= 1'b1;
		dbg_bitslip_i_i <= 1'b1;
		@(posedge sys_clk_i);
		dbg_bitslip_i_i <= 1'b0;
		wait_valid(3);
		@(posedge sys_clk_i);
		chk_manual <= 1'b1;
		wait_valid(4);
		@(posedge sys_clk_i);
		chk_manual <= 1'b0;
		chk_hold <= 1'b0;
		report("manual_slip", f);

		// release pin and recalibrate
		f = fail_cnt;
		dbg_control_pin_i <= 1'b0;
		repeat (4) @(negedge sys_clk_i);
		while (!adc_calib_complete_o) @(negedge sys_clk_i);
		@(posedge sys_clk_i);
		chk_train <= 1'b1;
		wait_valid(8);
		report("recalib", f);

		// dead I lane 3
		f = fail_cnt;
		@(posedge sys_clk_i);
		chk_train <= 1'b0;
		chk_noerr <= 1'b0;
		zero_lanes <= LANES'(1) << 3;
		dbg_control_pin_i <= 1'b1;
		repeat (4) @(posedge sys_clk_i);
		chk_errcase <= 1'b1;
		dbg_control_pin_i <= 1'b0;
		@(negedge sys_clk_i);
		while (!calib_error_o) @(negedge sys_clk_i);
		wait_valid(4);
		@(posedge sys_clk_i);
		chk_errcase <= 1'b0;
		@(posedge sys_clk_i);
		report("dead_lane", f);

		$display("tests run %0d, failed checks %0d", tests_run, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
